// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = tb_flat_mlsd
FILELIST  = project.f
BUILD_DIR = obj_dir
BIN       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000
SOURCES   = $(shell grep -v '^+' $(FILELIST)) mlsd_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== est_regfile.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mlsd_params.svh"

module est_regfile (
	input wire logic clk,
	input wire logic rstb,
	input wire mlsd_pkg::wbReq_t wbReq,
	output mlsd_pkg::wbRsp_t wbRsp,
	output mlsd_pkg::estTable_t estTable
);

	localparam int laneBits = `WB_ADR_BITS - 2;

	logic [1:0] tapSel;
	logic [laneBits-1:0] laneSel;
	logic hit;
	logic ack;
	logic accept;

	// address is lane times 4 plus tap.
	assign tapSel = wbReq.adr[1:0];
	assign laneSel = wbReq.adr[`WB_ADR_BITS-1:2];
	assign hit = (int'(tapSel) < `EST_DEPTH) && (int'(laneSel) < `NUM_CHANNELS);

	// a held request is taken once, then ack drops for a cycle.
	assign accept = wbReq.cyc && wbReq.stb && !ack;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			ack <= 1'b0;
			estTable <= '0;
		end else begin
			ack <= accept;
			if (accept && wbReq.we && hit) begin
				estTable[laneSel][tapSel] <= wbReq.datWr;
			end
		end
	end

	// read data is valid while the master holds the address during ack.
	always_comb begin
		wbRsp.ack = ack;
		if (hit) begin
			wbRsp.datRd = estTable[laneSel][tapSel];
		end else begin
			wbRsp.datRd = '0;
		end
	end

endmodule

`default_nettype wire

// ==== flat_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mlsd_params.svh"

module flat_buffer #(
	parameter int width = 8,
	parameter int depth = 3,
	parameter int lag = 0
) (
	input wire logic clk,
	input wire logic rstb,
	input wire logic [`NUM_CHANNELS-1:0][width-1:0] in,
	output logic [depth*`NUM_CHANNELS-1:0][width-1:0] flatOut
);

	// the input arrives lag words behind the stream it belongs to.
	localparam int numStages = depth - lag;

	logic [numStages-1:0][`NUM_CHANNELS-1:0][width-1:0] words;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			words <= '0;
		end else begin
			words[0] <= in;
			for (int s = 1; s < numStages; s++) begin
				words[s] <= words[s-1];
			end
		end
	end

	// oldest word at the low end, so the flat index runs forward in time.
	for (genvar w = 0; w < depth; w++) begin : gWord
		if (w < lag) begin : gPending
			// not received yet.
			assign flatOut[(depth-1-w)*`NUM_CHANNELS +: `NUM_CHANNELS] = '0;
		end else begin : gStored
			assign flatOut[(depth-1-w)*`NUM_CHANNELS +: `NUM_CHANNELS] = words[w-lag];
		end
	end

endmodule

`default_nettype wire

// ==== flat_mlsd.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mlsd_params.svh"

module flat_mlsd (
	input wire logic clk,
	input wire logic rstb,
	input wire mlsd_pkg::codeWord_t codes,
	input wire mlsd_pkg::bitWord_t estimateBits,
	input wire mlsd_pkg::wbReq_t wbReq,
	output mlsd_pkg::wbRsp_t wbRsp,
	output mlsd_pkg::bitWord_t predictBits
);

	import mlsd_pkg::*;

	estTable_t estTable;
	hypCodes_t hypCodes;
	logic [`BUF_DEPTH*`NUM_CHANNELS-1:0][`CODE_BITS-1:0] flatCodes;
	logic [`BUF_DEPTH*`NUM_CHANNELS-1:0] flatBits;

	est_regfile uEstRegfile (
		.clk      (clk),
		.rstb     (rstb),
		.wbReq    (wbReq),
		.wbRsp    (wbRsp),
		.estTable (estTable)
	);

	flat_buffer #(
		.width (`CODE_BITS),
		.depth (`BUF_DEPTH),
		.lag   (0)
	) uCodeBuffer (
		.clk     (clk),
		.rstb    (rstb),
		.in      (codes),
		.flatOut (flatCodes)
	);

	// slicer bits trail their codes by one word.
	flat_buffer #(
		.width (1),
		.depth (`BUF_DEPTH),
		.lag   (1)
	) uBitBuffer (
		.clk     (clk),
		.rstb    (rstb),
		.in      (estimateBits),
		.flatOut (flatBits)
	);

	potential_codes_gen uCodesGen (
		.flatBits (flatBits),
		.estTable (estTable),
		.hypCodes (hypCodes)
	);

	mlsd_decision uDecision (
		.clk         (clk),
		.rstb        (rstb),
		.flatCodes   (flatCodes),
		.hypCodes    (hypCodes),
		.predictBits (predictBits)
	);

endmodule

`default_nettype wire

// ==== flat_mlsd_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mlsd_params.svh"

module flat_mlsd_asserts (
	input wire logic clk,
	input wire logic rstb,
	input wire mlsd_pkg::wbReq_t wbReq,
	input wire mlsd_pkg::wbRsp_t wbRsp,
	input wire mlsd_pkg::bitWord_t predictBits
);

	int failures = 0;

	// ack answers a request that was present on the edge before.
	ackAfterRequest: assert property (@(posedge clk) disable iff (!rstb)
		wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))
	else begin
		$error("Wishbone ack raised without a request");
		failures++;
	end

	ackOneCycle: assert property (@(posedge clk) disable iff (!rstb)
		wbRsp.ack |=> !wbRsp.ack)
	else begin
		$error("Wishbone ack held longer than one cycle");
		failures++;
	end

	// outputs stay cleared while reset is held.
	quietInReset: assert property (@(posedge clk)
		!rstb |-> (!wbRsp.ack && predictBits == '0))
	else begin
		$error("ack or predictBits not zero during reset");
		failures++;
	end

endmodule

bind flat_mlsd flat_mlsd_asserts uAsserts (
	.clk         (clk),
	.rstb        (rstb),
	.wbReq       (wbReq),
	.wbRsp       (wbRsp),
	.predictBits (predictBits)
);

`default_nettype wire

// ==== mlsd_decision.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mlsd_params.svh"

module mlsd_decision (
	input wire logic clk,
	input wire logic rstb,
	input wire logic [`BUF_DEPTH*`NUM_CHANNELS-1:0][`CODE_BITS-1:0] flatCodes,
	input wire mlsd_pkg::hypCodes_t hypCodes,
	output mlsd_pkg::bitWord_t predictBits
);

	import mlsd_pkg::*;

	localparam int centerBase = (`BUF_DEPTH - 1 - `CENTER_WORD) * `NUM_CHANNELS;

	bitWord_t nextBits;

	always_comb begin
		logic signed [`ERR_BITS-1:0] diff;
		logic [`ERR_BITS-1:0] err;
		logic [`ERR_BITS-1:0] bestErr;
		logic [`NBIT-1:0] best;
		nextBits = '0;
		for (int l = 0; l < `NUM_CHANNELS; l++) begin
			best = '0;
			bestErr = '1;
			for (int h = 0; h < 2**`NBIT; h++) begin
				err = '0;
				for (int p = 0; p < `SEQ_LEN; p++) begin
					diff = $signed(flatCodes[centerBase+l+p]) - $signed(hypCodes[l][h][p]);
					err = err + $unsigned(diff * diff);
				end
				// strict compare keeps the lowest index on a tie.
				if (err < bestErr) begin
					bestErr = err;
					best = `NBIT'(h);
				end
			end
			// hypothesis bit 0 is the current symbol.
			nextBits[l] = best[0];
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			predictBits <= '0;
		end else begin
			predictBits <= nextBits;
		end
	end

endmodule

`default_nettype wire

// ==== mlsd_params.svh ====
`ifndef MLSD_PARAMS_SVH
`define MLSD_PARAMS_SVH

// lanes per received word.
`define NUM_CHANNELS 4

// signed ADC code and channel tap widths.
`define CODE_BITS 8
`define EST_BITS 8

// taps per lane, positions compared and hypothesis bits.
`define EST_DEPTH 3
`define SEQ_LEN 2
`define NBIT 2

// sum of squared errors, wide enough for all code and tap values.
`define ERR_BITS 24

// flat buffer words: one past, the center, one future. word 0 is the newest.
`define BUF_DEPTH 3
`define CENTER_WORD 1

`define WB_ADR_BITS 4

`endif

// ==== mlsd_pkg.sv ====
`default_nettype none

`include "mlsd_params.svh"

package mlsd_pkg;

	typedef logic signed [`CODE_BITS-1:0] code_t;
	typedef logic signed [`EST_BITS-1:0] est_t;

	// expected code, a sum of EST_DEPTH signed taps.
	typedef logic signed [`EST_BITS+$clog2(`EST_DEPTH)-1:0] expCode_t;

	typedef code_t [`NUM_CHANNELS-1:0] codeWord_t;
	typedef logic [`NUM_CHANNELS-1:0] bitWord_t;

	typedef est_t [`EST_DEPTH-1:0] laneTaps_t;
	typedef laneTaps_t [`NUM_CHANNELS-1:0] estTable_t;

	// indexed as [lane][hypothesis][position].
	typedef expCode_t [`NUM_CHANNELS-1:0][2**`NBIT-1:0][`SEQ_LEN-1:0] hypCodes_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`WB_ADR_BITS-1:0] adr;
		logic [`EST_BITS-1:0] datWr;
	} wbReq_t;

	typedef struct packed {
		logic ack;
		logic [`EST_BITS-1:0] datRd;
	} wbRsp_t;

endpackage

`default_nettype wire

// ==== potential_codes_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mlsd_params.svh"

module potential_codes_gen (
	input wire logic [`BUF_DEPTH*`NUM_CHANNELS-1:0] flatBits,
	input wire mlsd_pkg::estTable_t estTable,
	output mlsd_pkg::hypCodes_t hypCodes
);

	import mlsd_pkg::*;

	// flat index of lane 0 of the center word.
	localparam int centerBase = (`BUF_DEPTH - 1 - `CENTER_WORD) * `NUM_CHANNELS;

	always_comb begin
		expCode_t acc;
		est_t tap;
		logic [`NBIT-1:0] hyp;
		logic symBit;
		int smp;
		int ofs;
		int tapLane;
		for (int l = 0; l < `NUM_CHANNELS; l++) begin
			for (int h = 0; h < 2**`NBIT; h++) begin
				hyp = `NBIT'(h);
				for (int p = 0; p < `SEQ_LEN; p++) begin
					// each sample is predicted with the taps of its own lane.
					tapLane = (l + p) % `NUM_CHANNELS;
					acc = '0;
					for (int k = 0; k < `EST_DEPTH; k++) begin
						smp = centerBase + l + p - k;
						ofs = p - k;
						if (ofs >= 0 && ofs < `NBIT) begin
							symBit = hyp[ofs];
						end else begin
							symBit = flatBits[smp];
						end
						tap = estTable[tapLane][k];
						// bit 1 is +1, bit 0 is -1.
						if (symBit) begin
							acc = acc + expCode_t'(tap);
						end else begin
							acc = acc - expCode_t'(tap);
						end
					end
					hypCodes[l][h][p] = acc;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
mlsd_pkg.sv
est_regfile.sv
flat_buffer.sv
potential_codes_gen.sv
mlsd_decision.sv
flat_mlsd.sv
flat_mlsd_asserts.sv
tb_flat_mlsd.sv

// ==== tb_flat_mlsd.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mlsd_params.svh"

module tb_flat_mlsd;

	import mlsd_pkg::*;

	localparam int driveDelay = 1;
	localparam int checkDelay = 5;
	localparam int ackTimeout = 20;
	localparam int numAdr = 2**`WB_ADR_BITS;
	localparam int maxCode = 2**(`CODE_BITS-1) - 1;

	logic clk = 1'b0;
	logic rstb = 1'b0;
	codeWord_t codes = '0;
	bitWord_t estimateBits = '0;
	wbReq_t wbReq = '0;
	wbRsp_t wbRsp;
	bitWord_t predictBits;

	int seed = 32'h05716221;
	int errors = 0;
	int checks = 0;
	int noiseAmp = 0;
	logic streamOn = 1'b0;
	logic compareOn = 1'b0;
	logic truthCheck = 1'b0;
	// taps indexed [lane][tap] for the stimulus and the model.
	int taps [`NUM_CHANNELS][`EST_DEPTH];
	bitWord_t trueBits = '0;
	// model copies of the words held in the DUT buffers.
	codeWord_t codesNew = '0;
	codeWord_t codesCenter = '0;
	bitWord_t bitsCenter = '0;
	bitWord_t bitsPast = '0;
	bitWord_t truthNew = '0;
	bitWord_t truthCenter = '0;

	flat_mlsd u_flat_mlsd (
		.clk          (clk),
		.rstb         (rstb),
		.codes        (codes),
		.estimateBits (estimateBits),
		.wbReq        (wbReq),
		.wbRsp        (wbRsp),
		.predictBits  (predictBits)
	);

	always #50 clk = ~clk;

	function automatic int polar(input logic b);
		return b ? 1 : -1;
	endfunction

	// minimum squared error decision for the center word.
	// a tie goes to the lower hypothesis.
	function automatic bitWord_t modelDecision();
		bitWord_t result;
		logic [2*`NUM_CHANNELS-1:0] hist;
		logic [2*`NUM_CHANNELS-1:0][`CODE_BITS-1:0] rx;
		int nl, cur, nxt, past1, past2, rxCur, rxNext;
		int expCur, expNext, err, bestErr;
		result = '0;
		bestErr = 0;
		hist = {bitsCenter, bitsPast};
		rx = {codesNew, codesCenter};
		for (int l = 0; l < `NUM_CHANNELS; l++) begin
			// the next sample sits in the following lane and uses its taps.
			nl = (l + 1) % `NUM_CHANNELS;
			past1 = polar(hist[`NUM_CHANNELS+l-1]);
			past2 = polar(hist[`NUM_CHANNELS+l-2]);
			rxCur = $signed(rx[l]);
			rxNext = $signed(rx[l+1]);
			for (int h = 0; h < 2**`NBIT; h++) begin
				cur = polar(h % 2 == 1);
				nxt = polar(h / 2 == 1);
				expCur = taps[l][0] * cur + taps[l][1] * past1 + taps[l][2] * past2;
				expNext = taps[nl][0] * nxt + taps[nl][1] * cur + taps[nl][2] * past1;
				err = (rxCur - expCur) * (rxCur - expCur) + (rxNext - expNext) * (rxNext - expNext);
				if (h == 0 || err < bestErr) begin
					bestErr = err;
					result[l] = (h % 2 == 1);
				end
			end
		end
		return result;
	endfunction

	// new true bits go through the channel taps and get noise added.
	// slicer bits trail by one word.
	task automatic driveWord();
		bitWord_t newBits;
		logic [2*`NUM_CHANNELS-1:0] syms;
		int acc;
		newBits = bitWord_t'($random(seed));
		syms = {newBits, trueBits};
		for (int l = 0; l < `NUM_CHANNELS; l++) begin
			acc = taps[l][0] * polar(syms[`NUM_CHANNELS+l])
				+ taps[l][1] * polar(syms[`NUM_CHANNELS+l-1])
				+ taps[l][2] * polar(syms[`NUM_CHANNELS+l-2]);
			if (noiseAmp > 0) begin
				acc = acc + $random(seed) % (noiseAmp + 1);
			end
			acc = (acc > maxCode) ? maxCode : ((acc < -maxCode - 1) ? -maxCode - 1 : acc);
			codes[l] = code_t'(acc);
		end
		estimateBits = trueBits;
		trueBits = newBits;
	endtask

	always @(posedge clk) begin
		#driveDelay;
		if (streamOn) begin
			driveWord();
		end
	end

	// model follows the DUT edge by edge and checks each registered decision.
	always @(posedge clk) begin
		codeWord_t sampCodes;
		bitWord_t sampBits;
		bitWord_t sampTruth;
		bitWord_t expBits;
		wbReq_t sampReq;
		logic sampRstb;
		sampCodes = codes;
		sampBits = estimateBits;
		sampTruth = trueBits;
		sampReq = wbReq;
		sampRstb = rstb;
		#checkDelay;
		if (!sampRstb) begin
			codesNew = '0;
			codesCenter = '0;
			bitsCenter = '0;
			bitsPast = '0;
			truthNew = '0;
			truthCenter = '0;
			for (int l = 0; l < `NUM_CHANNELS; l++) begin
				for (int k = 0; k < `EST_DEPTH; k++) begin
					taps[l][k] = 0;
				end
			end
			checks++;
			assert (predictBits == '0 && !wbRsp.ack) else begin
				$display("Error at %0t: ack or predictBits not zero in reset", $time);
				errors++;
			end
		end else begin
			expBits = modelDecision();
			if (compareOn) begin
				checks++;
				assert (predictBits == expBits) else begin
					$display("Error at %0t: predictBits %b, model expects %b", $time,
						predictBits, expBits);
					errors++;
				end
				if (truthCheck) begin
					checks++;
					assert (predictBits == truthCenter) else begin
						$display("Error at %0t: predictBits %b, true bits %b", $time,
							predictBits, truthCenter);
						errors++;
					end
				end
			end
			codesCenter = codesNew;
			codesNew = sampCodes;
			bitsPast = bitsCenter;
			bitsCenter = sampBits;
			truthCenter = truthNew;
			truthNew = sampTruth;
			// a write counts from the edge that raised its ack.
			if (wbRsp.ack && sampReq.we && int'(sampReq.adr % 4) < `EST_DEPTH) begin
				taps[sampReq.adr / 4][sampReq.adr % 4] = $signed(sampReq.datWr);
			end
		end
	end

	task automatic busCycle(input logic we, input int adr, input logic [7:0] wdata,
			output logic [7:0] rdata);
		int waited;
		@(posedge clk);
		#driveDelay;
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: `WB_ADR_BITS'(adr), datWr: wdata};
		waited = 0;
		do begin
			@(posedge clk);
			#driveDelay;
			waited++;
		end while (!wbRsp.ack && waited < ackTimeout);
		rdata = wbRsp.datRd;
		if (!wbRsp.ack) begin
			$display("Wishbone request to address %0d got no ack in %0d cycles", adr, waited);
			errors++;
		end
		wbReq = '0;
	endtask

	task automatic checkRead(input int adr, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("Error at %0t: address %0d read %h, expected %h", $time, adr, got, exp);
			errors++;
		end
	endtask

	task automatic reportTest(input int num, input string name, input int errBase);
		$display("Test %0d (%s) finished with %0d errors", num, name, errors - errBase);
	endtask

	initial begin
		logic [7:0] rd;
		logic [7:0] wr [numAdr];
		int errBase;
		int adr;
		int assertFails;
		errBase = errors;
		repeat (16) @(posedge clk);
		#driveDelay;
		rstb = 1'b1;
		repeat (2) @(posedge clk);
		#driveDelay;
		checks++;
		assert (predictBits == '0 && !wbRsp.ack) else begin
			$display("Error at %0t: outputs not zero after reset", $time);
			errors++;
		end
		for (adr = 0; adr < numAdr; adr++) begin
			busCycle(1'b0, adr, 8'h00, rd);
			checkRead(adr, rd, 8'h00);
		end
		reportTest(1, "reset", errBase);

		errBase = errors;
		for (adr = 0; adr < numAdr; adr++) begin
			wr[adr] = 8'($random(seed));
			busCycle(1'b1, adr, wr[adr], rd);
		end
		for (adr = 0; adr < numAdr; adr++) begin
			busCycle(1'b0, adr, 8'h00, rd);
			checkRead(adr, rd, (adr % 4 < `EST_DEPTH) ? wr[adr] : 8'h00);
		end
		reportTest(2, "tap access", errBase);

		// tap 0 outweighs the others, so the true sequence is the unique zero-error one.
		errBase = errors;
		for (int l = 0; l < `NUM_CHANNELS; l++) begin
			busCycle(1'b1, l * 4, 8'(40 + {$random(seed)} % 40), rd);
			busCycle(1'b1, l * 4 + 1, 8'($random(seed) % 16), rd);
			busCycle(1'b1, l * 4 + 2, 8'($random(seed) % 16), rd);
		end
		@(posedge clk);
		noiseAmp = 0;
		streamOn = 1'b1;
		repeat (`BUF_DEPTH + 1) @(posedge clk);
		compareOn = 1'b1;
		truthCheck = 1'b1;
		repeat (200) @(posedge clk);
		truthCheck = 1'b0;
		reportTest(3, "noise-free detection", errBase);

		// zero taps now and then give ties between hypotheses.
		errBase = errors;
		noiseAmp = 3;
		for (adr = 0; adr < numAdr; adr++) begin
			if ({$random(seed)} % 4 == 0) begin
				busCycle(1'b1, adr, 8'h00, rd);
			end else begin
				busCycle(1'b1, adr, 8'($random(seed) % 41), rd);
			end
		end
		// lane 0 gets no weight on its current bit and ties on every word.
		busCycle(1'b1, 0, 8'h00, rd);
		busCycle(1'b1, 1 * 4 + 1, 8'h00, rd);
		repeat (300) @(posedge clk);
		reportTest(4, "model match", errBase);

		errBase = errors;
		for (int i = 0; i < 24; i++) begin
			adr = {$random(seed)} % numAdr;
			busCycle(1'b1, adr, 8'($random(seed) % 41), rd);
			repeat ({$random(seed)} % 4) @(posedge clk);
		end
		repeat (`BUF_DEPTH + 1) @(posedge clk);
		compareOn = 1'b0;
		streamOn = 1'b0;
		reportTest(5, "live reconfiguration", errBase);

		assertFails = u_flat_mlsd.uAsserts.failures;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			assertFails);
		if (errors == 0 && assertFails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
